//--- verilog/motor_regs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Motor register map: address layout, field positions and byte types
// shared by the register banks and the readback path
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package motor_regs_pkg;

    typedef logic [5:0]  reg_addr_t;    // Host address, 64 locations
    typedef logic [7:0]  reg_data_t;    // One register byte
    typedef logic [4:0]  pwm_t;         // Drive duty cycle
    typedef logic [6:0]  drive_temp_t;  // Drive ADC temperature
    typedef logic [5:0]  rot_temp_t;    // Low ADC bits only
    typedef logic [11:0] angle_t;       // Rotation angle

    localparam int NUM_DRIVE    = 4;
    localparam int NUM_ROTATION = 4;

    // Broadcast writes, address 0x00 stays reserved
    localparam reg_addr_t ADDR_BCAST_ALL      = 6'h01;
    localparam reg_addr_t ADDR_BCAST_ROTATION = 6'h02;
    localparam reg_addr_t ADDR_BCAST_DRIVE    = 6'h03;

    // Drive channels, two bytes each
    localparam reg_addr_t DRIVE_BASE   = 6'h04;
    localparam int        DRIVE_STRIDE = 2;
    localparam int        DRIVE_CTRL   = 0;
    localparam int        DRIVE_STATUS = 1;

    // Rotation channels, five bytes each
    localparam reg_addr_t ROTATION_BASE   = 6'h0C;
    localparam int        ROTATION_STRIDE = 5;
    localparam int        ROT_CTRL        = 0;
    localparam int        ROT_STATUS      = 1;
    localparam int        ROT_TARGET      = 2;
    localparam int        ROT_CURR_LO     = 3;
    localparam int        ROT_CURR_HI     = 4;
    localparam reg_addr_t ROTATION_END    = 6'h20;  // First address past the map

    // Control byte fields
    localparam int BRAKE_BIT     = 7;
    localparam int ENABLE_BIT    = 6;
    localparam int DIRECTION_BIT = 5;

    // ROT_CURR_HI: strobes on write, done flag on read
    localparam int ABORT_BIT      = 4;
    localparam int UPDATE_BIT     = 5;
    localparam int ANGLE_DONE_BIT = 7;

    // Angle bits above the low byte, held in control nibble / CURR_HI
    localparam int ANGLE_HI_W = $bits(angle_t) - $bits(reg_data_t);

endpackage

`default_nettype wire

//--- verilog/reg_bus_if.sv
////////////////////////////////////////////////////////////////////////////
// Host register bus, fanned out to both banks and the readback mux
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;
    import motor_regs_pkg::*;

    reg_addr_t address;     // Shared read / write address
    logic      write_en;    // Write on every edge this is high
    reg_data_t wr_data;
    logic      read_en;     // Read on every edge this is high

    // Top level drives the bus from its ports
    modport host (
        output address, write_en, wr_data, read_en
    );

    // Banks decode writes and reads
    modport bank (
        input  address, write_en, wr_data
    );

    // Read side only
    modport reader (
        input  address, read_en
    );

endinterface

`default_nettype wire

//--- verilog/drive_bank.sv
////////////////////////////////////////////////////////////////////////////
// Drive motor bank: control and status bytes for the four drive channels
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module drive_bank (
    input  logic                                               clock,
    input  logic                                               reset,
    reg_bus_if.bank                                            bus,
    input  logic [motor_regs_pkg::NUM_DRIVE-1:0]               fault,
    input  motor_regs_pkg::drive_temp_t [motor_regs_pkg::NUM_DRIVE-1:0] adc_temp,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]               brake,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]               enable,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]               direction,
    output motor_regs_pkg::pwm_t [motor_regs_pkg::NUM_DRIVE-1:0] pwm,
    output motor_regs_pkg::reg_data_t                          read_data,
    output logic                                               hit
);
    import motor_regs_pkg::*;

    reg_data_t              ctrl_q   [NUM_DRIVE];  // Host written
    reg_data_t              status_q [NUM_DRIVE];  // Sampled every cycle
    logic [NUM_DRIVE-1:0]   ctrl_sel;              // Address decode per byte
    logic [NUM_DRIVE-1:0]   status_sel;
    logic                   bcast_wr;

    // Address of one byte of one channel
    function automatic reg_addr_t drive_addr(input int ch, input int offset);
        return reg_addr_t'(DRIVE_BASE + ch * DRIVE_STRIDE + offset);
    endfunction

    assign bcast_wr = bus.write_en &&
                      (bus.address == ADDR_BCAST_DRIVE || bus.address == ADDR_BCAST_ALL);

    for (genvar g = 0; g < NUM_DRIVE; g++) begin : g_chan
        assign ctrl_sel[g]   = (bus.address == drive_addr(g, DRIVE_CTRL));
        assign status_sel[g] = (bus.address == drive_addr(g, DRIVE_STATUS));

        // Control byte fields out to the motor driver
        assign brake[g]     = ctrl_q[g][BRAKE_BIT];
        assign enable[g]    = ctrl_q[g][ENABLE_BIT];
        assign direction[g] = ctrl_q[g][DIRECTION_BIT];
        assign pwm[g]       = ctrl_q[g][$bits(pwm_t)-1:0];  // Duty in the low bits
    end

    // Control bytes, own address or drive / global broadcast
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int ch = 0; ch < NUM_DRIVE; ch++) begin
                ctrl_q[ch] <= '0;
            end
        end else begin
            for (int ch = 0; ch < NUM_DRIVE; ch++) begin
                if (bcast_wr || (bus.write_en && ctrl_sel[ch]))
                    ctrl_q[ch] <= bus.wr_data;
            end
        end
    end

    // Status capture, reloads on the first edge out of reset
    always_ff @(posedge clock) begin
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            status_q[ch] <= {fault[ch], adc_temp[ch]};  // Fault on top of temp
        end
    end

    // Readback from registered contents
    always_comb begin
        read_data = '0;
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            if (ctrl_sel[ch])
                read_data = ctrl_q[ch];
            if (status_sel[ch])
                read_data = status_q[ch];
        end
    end

    assign hit = |{ctrl_sel, status_sel};  // Same decode as the read mux

endmodule

`default_nettype wire

//--- verilog/rotation_bank.sv
////////////////////////////////////////////////////////////////////////////
// Rotation motor bank: control, target, status and current angle bytes,
// plus the single-cycle abort and update strobes per channel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rotation_bank (
    input  logic                                                   clock,
    input  logic                                                   reset,
    reg_bus_if.bank                                                bus,
    input  logic [motor_regs_pkg::NUM_ROTATION-1:0]                fault,
    input  logic [motor_regs_pkg::NUM_ROTATION-1:0]                startup_fail,
    input  motor_regs_pkg::rot_temp_t [motor_regs_pkg::NUM_ROTATION-1:0] adc_temp,
    input  motor_regs_pkg::angle_t [motor_regs_pkg::NUM_ROTATION-1:0] current_angle,
    input  logic [motor_regs_pkg::NUM_ROTATION-1:0]                angle_done,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                brake,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                enable,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                direction,
    output motor_regs_pkg::angle_t [motor_regs_pkg::NUM_ROTATION-1:0] target_angle,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                update_angle,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                abort_angle,
    output motor_regs_pkg::reg_data_t                              read_data,
    output logic                                                   hit
);
    import motor_regs_pkg::*;

    reg_data_t                ctrl_q    [NUM_ROTATION];  // Brake/enable/dir + target hi
    reg_data_t                target_q  [NUM_ROTATION];  // Target angle low byte
    reg_data_t                status_q  [NUM_ROTATION];
    reg_data_t                curr_lo_q [NUM_ROTATION];
    reg_data_t                curr_hi_q [NUM_ROTATION];
    reg_data_t                hi_capture [NUM_ROTATION]; // Done flag + angle nibble
    logic [NUM_ROTATION-1:0]  ctrl_sel;
    logic [NUM_ROTATION-1:0]  status_sel;
    logic [NUM_ROTATION-1:0]  target_sel;
    logic [NUM_ROTATION-1:0]  lo_sel;
    logic [NUM_ROTATION-1:0]  hi_sel;
    logic                     bcast_wr;

    function automatic reg_addr_t rot_addr(input int ch, input int offset);
        return reg_addr_t'(ROTATION_BASE + ch * ROTATION_STRIDE + offset);
    endfunction

    assign bcast_wr = bus.write_en &&
                      (bus.address == ADDR_BCAST_ROTATION || bus.address == ADDR_BCAST_ALL);

    for (genvar g = 0; g < NUM_ROTATION; g++) begin : g_chan
        assign ctrl_sel[g]   = (bus.address == rot_addr(g, ROT_CTRL));
        assign status_sel[g] = (bus.address == rot_addr(g, ROT_STATUS));
        assign target_sel[g] = (bus.address == rot_addr(g, ROT_TARGET));
        assign lo_sel[g]     = (bus.address == rot_addr(g, ROT_CURR_LO));
        assign hi_sel[g]     = (bus.address == rot_addr(g, ROT_CURR_HI));

        assign brake[g]        = ctrl_q[g][BRAKE_BIT];
        assign enable[g]       = ctrl_q[g][ENABLE_BIT];
        assign direction[g]    = ctrl_q[g][DIRECTION_BIT];
        assign target_angle[g] = {ctrl_q[g][ANGLE_HI_W-1:0], target_q[g]};

        // Strobe only follows a write to this channel's CURR_HI
        a_strobe_after_write : assert property (
            @(posedge clock) disable iff (reset)
            (abort_angle[g] || update_angle[g]) |-> $past(bus.write_en && hi_sel[g])
        );
    end

    // Host writable bytes and strobes
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int ch = 0; ch < NUM_ROTATION; ch++) begin
                ctrl_q[ch]   <= '0;
                target_q[ch] <= '0;
            end
            abort_angle  <= '0;
            update_angle <= '0;
        end else begin
            for (int ch = 0; ch < NUM_ROTATION; ch++) begin
                if (bcast_wr || (bus.write_en && ctrl_sel[ch]))
                    ctrl_q[ch] <= bus.wr_data;
                if (bus.write_en && target_sel[ch])  // No broadcast for targets
                    target_q[ch] <= bus.wr_data;
                // One cycle pulse, never stored
                abort_angle[ch]  <= bus.write_en && hi_sel[ch] && bus.wr_data[ABORT_BIT];
                update_angle[ch] <= bus.write_en && hi_sel[ch] && bus.wr_data[UPDATE_BIT];
            end
        end
    end

    always_comb begin
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            hi_capture[ch] = '0;
            hi_capture[ch][ANGLE_DONE_BIT] = angle_done[ch];
            hi_capture[ch][ANGLE_HI_W-1:0] = current_angle[ch][$bits(angle_t)-1 -: ANGLE_HI_W];
        end
    end

    // Status and angle sampling, every edge
    always_ff @(posedge clock) begin
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            status_q[ch]  <= {fault[ch], startup_fail[ch], adc_temp[ch]};
            curr_lo_q[ch] <= current_angle[ch][$bits(reg_data_t)-1:0];
            curr_hi_q[ch] <= hi_capture[ch];
        end
    end

    always_comb begin
        read_data = '0;
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            if (ctrl_sel[ch])
                read_data = ctrl_q[ch];
            if (status_sel[ch])
                read_data = status_q[ch];
            if (target_sel[ch])
                read_data = target_q[ch];
            if (lo_sel[ch])
                read_data = curr_lo_q[ch];
            if (hi_sel[ch])
                read_data = curr_hi_q[ch];  // Strobe bits read as zero
        end
    end

    assign hit = |{ctrl_sel, status_sel, target_sel, lo_sel, hi_sel};

endmodule

`default_nettype wire

//--- verilog/readback_mux.sv
////////////////////////////////////////////////////////////////////////////
// Readback mux: picks the claiming bank and registers rd_data on read_en
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module readback_mux (
    input  logic                      clock,
    input  logic                      reset,
    reg_bus_if.reader                 bus,
    input  motor_regs_pkg::reg_data_t drive_data,
    input  motor_regs_pkg::reg_data_t rotation_data,
    input  logic                      drive_hit,
    input  logic                      rotation_hit,
    output motor_regs_pkg::reg_data_t rd_data
);
    import motor_regs_pkg::*;

    reg_data_t read_sel;  // Next read value

    // Unclaimed addresses read as zero
    always_comb begin
        if (drive_hit)
            read_sel = drive_data;
        else if (rotation_hit)
            read_sel = rotation_data;
        else
            read_sel = '0;
    end

    // Holds between reads
    always_ff @(posedge clock) begin
        if (reset)
            rd_data <= '0;
        else if (bus.read_en)
            rd_data <= read_sel;
    end

    // Bank maps must not overlap
    a_one_hit : assert property (
        @(posedge clock) disable iff (reset)
        !(drive_hit && rotation_hit)
    );

    // Reserved, broadcast and unmapped reads stay unclaimed
    a_unmapped_no_hit : assert property (
        @(posedge clock) disable iff (reset)
        (bus.read_en && (bus.address < DRIVE_BASE || bus.address >= ROTATION_END))
            |-> !(drive_hit || rotation_hit)
    );

endmodule

`default_nettype wire

//--- verilog/motor_reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Motor control register file: host byte bus onto drive and rotation banks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module motor_reg_file (
    input  logic                                                   clock,
    input  logic                                                   reset,

    // Host port
    input  motor_regs_pkg::reg_addr_t                              address,
    input  logic                                                   write_en,
    input  motor_regs_pkg::reg_data_t                              wr_data,
    input  logic                                                   read_en,
    output motor_regs_pkg::reg_data_t                              rd_data,

    // Drive channels
    input  logic [motor_regs_pkg::NUM_DRIVE-1:0]                   drive_fault,
    input  motor_regs_pkg::drive_temp_t [motor_regs_pkg::NUM_DRIVE-1:0] drive_adc_temp,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]                   drive_brake,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]                   drive_enable,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]                   drive_direction,
    output motor_regs_pkg::pwm_t [motor_regs_pkg::NUM_DRIVE-1:0]   drive_pwm,

    // Rotation channels
    input  logic [motor_regs_pkg::NUM_ROTATION-1:0]                rot_fault,
    input  logic [motor_regs_pkg::NUM_ROTATION-1:0]                rot_startup_fail,
    input  motor_regs_pkg::rot_temp_t [motor_regs_pkg::NUM_ROTATION-1:0] rot_adc_temp,
    input  motor_regs_pkg::angle_t [motor_regs_pkg::NUM_ROTATION-1:0] current_angle,
    input  logic [motor_regs_pkg::NUM_ROTATION-1:0]                angle_done,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                rot_brake,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                rot_enable,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                rot_direction,
    output motor_regs_pkg::angle_t [motor_regs_pkg::NUM_ROTATION-1:0] target_angle,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                update_angle,
    output logic [motor_regs_pkg::NUM_ROTATION-1:0]                abort_angle
);
    import motor_regs_pkg::*;

    reg_data_t drive_data;     // Bank read values, combinational
    reg_data_t rotation_data;
    logic      drive_hit;
    logic      rotation_hit;

    reg_bus_if bus ();

    // Host side of the bus, straight from the ports
    assign bus.address  = address;
    assign bus.write_en = write_en;
    assign bus.wr_data  = wr_data;
    assign bus.read_en  = read_en;

    drive_bank u_drive_bank (
        .clock      (clock),
        .reset      (reset),
        .bus        (bus),
        .fault      (drive_fault),
        .adc_temp   (drive_adc_temp),
        .brake      (drive_brake),
        .enable     (drive_enable),
        .direction  (drive_direction),
        .pwm        (drive_pwm),
        .read_data  (drive_data),
        .hit        (drive_hit)
    );

    rotation_bank u_rotation_bank (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus),
        .fault          (rot_fault),
        .startup_fail   (rot_startup_fail),
        .adc_temp       (rot_adc_temp),
        .current_angle  (current_angle),
        .angle_done     (angle_done),
        .brake          (rot_brake),
        .enable         (rot_enable),
        .direction      (rot_direction),
        .target_angle   (target_angle),
        .update_angle   (update_angle),
        .abort_angle    (abort_angle),
        .read_data      (rotation_data),
        .hit            (rotation_hit)
    );

    // One register stage on the read path
    readback_mux u_readback_mux (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus),
        .drive_data     (drive_data),
        .rotation_data  (rotation_data),
        .drive_hit      (drive_hit),
        .rotation_hit   (rotation_hit),
        .rd_data        (rd_data)
    );

endmodule

`default_nettype wire

//--- tb/tb_reg_model.svh
////////////////////////////////////////////////////////////////////////////
// Register map reference model: shadow bytes, expected reads, value check
////////////////////////////////////////////////////////////////////////////
`ifndef TB_REG_MODEL_SVH
`define TB_REG_MODEL_SVH

// Map limits, first address past each bank
localparam int DRIVE_END = int'(DRIVE_BASE) + NUM_DRIVE * DRIVE_STRIDE;
localparam int ROT_END   = int'(ROTATION_BASE) + NUM_ROTATION * ROTATION_STRIDE;

reg_data_t drive_ctrl_sh [NUM_DRIVE];     // Shadow of host-written bytes
reg_data_t rot_ctrl_sh   [NUM_ROTATION];
reg_data_t rot_target_sh [NUM_ROTATION];  // Target angle low byte

// Post-reset map
task automatic model_reset();
    for (int ch = 0; ch < NUM_DRIVE; ch++) begin
        drive_ctrl_sh[ch] = '0;
    end
    for (int ch = 0; ch < NUM_ROTATION; ch++) begin
        rot_ctrl_sh[ch]   = '0;
        rot_target_sh[ch] = '0;
    end
endtask

// Own address or broadcast; CURR_HI writes leave no state
task automatic model_write(input reg_addr_t addr, input reg_data_t data);
    int a;
    a = int'(addr);
    for (int ch = 0; ch < NUM_DRIVE; ch++) begin
        if (addr == ADDR_BCAST_ALL || addr == ADDR_BCAST_DRIVE ||
            a == int'(DRIVE_BASE) + ch * DRIVE_STRIDE)
            drive_ctrl_sh[ch] = data;
    end
    for (int ch = 0; ch < NUM_ROTATION; ch++) begin
        if (addr == ADDR_BCAST_ALL || addr == ADDR_BCAST_ROTATION ||
            a == int'(ROTATION_BASE) + ch * ROTATION_STRIDE)
            rot_ctrl_sh[ch] = data;
        if (a == int'(ROTATION_BASE) + ch * ROTATION_STRIDE + ROT_TARGET)
            rot_target_sh[ch] = data;  // Never broadcast
    end
endtask

// Read value from shadow bytes and the inputs held by the testbench
function automatic reg_data_t expected_read(input reg_addr_t addr);
    int ch;
    int off;
    reg_data_t value;
    value = '0;                                          // Unmapped default
    if (int'(addr) >= int'(DRIVE_BASE) && int'(addr) < DRIVE_END) begin
        ch  = (int'(addr) - int'(DRIVE_BASE)) / DRIVE_STRIDE;
        off = (int'(addr) - int'(DRIVE_BASE)) % DRIVE_STRIDE;
        if (off == 0)
            value = drive_ctrl_sh[ch];
        else
            value = {drive_fault[ch], drive_adc_temp[ch]};  // Fault over 7-bit temp
    end else if (int'(addr) >= int'(ROTATION_BASE) && int'(addr) < ROT_END) begin
        ch  = (int'(addr) - int'(ROTATION_BASE)) / ROTATION_STRIDE;
        off = (int'(addr) - int'(ROTATION_BASE)) % ROTATION_STRIDE;
        case (off)
            0: value = rot_ctrl_sh[ch];
            1: value = {rot_fault[ch], rot_startup_fail[ch], rot_adc_temp[ch]};
            2: value = rot_target_sh[ch];
            3: value = current_angle[ch][7:0];
            4: value = {angle_done[ch], 3'b000, current_angle[ch][11:8]};  // Done + top nibble
            default: value = '0;
        endcase
    end
    return value;
endfunction

// First mismatch ends the run
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("FAIL: see errors above");
        $fatal(1, "value mismatch");
    end
endtask

`endif

//--- tb/tb_motor_reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the motor register file: map, broadcasts, status, strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_motor_reg_file;
    import motor_regs_pkg::*;

    typedef drive_temp_t [NUM_DRIVE-1:0]  drive_temp_vec_t;
    typedef rot_temp_t [NUM_ROTATION-1:0] rot_temp_vec_t;
    typedef angle_t [NUM_ROTATION-1:0]    angle_vec_t;

    localparam int CLK_PERIOD_NS     = 4;
    localparam int RESET_CYCLES      = 4;
    localparam int RANDOM_SEED       = 40090;
    localparam int NUM_ACCESSES      = 64 + 48 + 84 + 112 + 16 + 32;  // Per test, in order
    localparam int CYCLES_PER_ACCESS = 4;                            // Access plus check waits
    localparam int WATCHDOG_NS       =
        2 * (RESET_CYCLES + NUM_ACCESSES * CYCLES_PER_ACCESS) * CLK_PERIOD_NS;

    logic                    clock;
    logic                    reset;
    reg_addr_t               address;
    logic                    write_en;
    reg_data_t               wr_data;
    logic                    read_en;
    reg_data_t               rd_data;
    logic [NUM_DRIVE-1:0]    drive_fault;
    drive_temp_vec_t         drive_adc_temp;
    logic [NUM_DRIVE-1:0]    drive_brake;
    logic [NUM_DRIVE-1:0]    drive_enable;
    logic [NUM_DRIVE-1:0]    drive_direction;
    pwm_t [NUM_DRIVE-1:0]    drive_pwm;
    logic [NUM_ROTATION-1:0] rot_fault;
    logic [NUM_ROTATION-1:0] rot_startup_fail;
    rot_temp_vec_t           rot_adc_temp;
    angle_vec_t              current_angle;
    logic [NUM_ROTATION-1:0] angle_done;
    logic [NUM_ROTATION-1:0] rot_brake;
    logic [NUM_ROTATION-1:0] rot_enable;
    logic [NUM_ROTATION-1:0] rot_direction;
    angle_vec_t              target_angle;
    logic [NUM_ROTATION-1:0] update_angle;
    logic [NUM_ROTATION-1:0] abort_angle;

    string     test_name;
    string     read_name;           // Captured with the read
    reg_data_t read_expected;
    bit        read_pending;
    int        reads_issued  = 0;
    int        reads_checked = 0;

    `include "tb_reg_model.svh"

    motor_reg_file uut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clock = ~clock;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    // Read checker; expected value taken one edge before the DUT samples
    always @(negedge clock) begin
        if (read_pending) begin
            check_value(read_name, 32'(read_expected), 32'(rd_data));
            reads_checked++;
        end
        read_pending = read_en && !reset;
        if (read_en && !reset) begin
            read_expected = expected_read(address);
            read_name     = $sformatf("%s read 0x%02h", test_name, address);
        end
    end

    function automatic reg_addr_t drive_reg(input int ch, input int off);
        return reg_addr_t'(int'(DRIVE_BASE) + ch * DRIVE_STRIDE + off);
    endfunction

    function automatic reg_addr_t rotation_reg(input int ch, input int off);
        return reg_addr_t'(int'(ROTATION_BASE) + ch * ROTATION_STRIDE + off);
    endfunction

    // One write cycle; model follows at the edge the DUT takes it
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clock);
        address  <= addr;
        wr_data  <= data;
        write_en <= 1'b1;
        @(posedge clock);
        write_en <= 1'b0;
        model_write(addr, data);
    endtask

    task automatic bus_read(input reg_addr_t addr);
        @(posedge clock);
        address <= addr;
        read_en <= 1'b1;
        reads_issued++;
        @(posedge clock);
        read_en <= 1'b0;
    endtask

    task automatic read_range(input int first, input int last);
        for (int a = first; a <= last; a++) begin
            bus_read(reg_addr_t'(a));
        end
    endtask

    // All host-written bytes
    task automatic read_controls();
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            bus_read(drive_reg(ch, DRIVE_CTRL));
        end
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            bus_read(rotation_reg(ch, ROT_CTRL));
            bus_read(rotation_reg(ch, ROT_TARGET));
        end
    endtask

    // Control fields, target angles and strobes against the shadow
    task automatic check_outputs(input logic [NUM_ROTATION-1:0] exp_abort,
                                 input logic [NUM_ROTATION-1:0] exp_update);
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            check_value($sformatf("%s drive %0d ctrl", test_name, ch),
                        32'(drive_ctrl_sh[ch]),
                        32'({drive_brake[ch], drive_enable[ch], drive_direction[ch],
                             drive_pwm[ch]}));
        end
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            check_value($sformatf("%s rotation %0d ctrl", test_name, ch),
                        32'(rot_ctrl_sh[ch][7:5]),                   // Brake, enable, dir
                        32'({rot_brake[ch], rot_enable[ch], rot_direction[ch]}));
            check_value($sformatf("%s rotation %0d target", test_name, ch),
                        32'({rot_ctrl_sh[ch][3:0], rot_target_sh[ch]}),
                        32'(target_angle[ch]));
        end
        check_value({test_name, " abort"}, 32'(exp_abort), 32'(abort_angle));
        check_value({test_name, " update"}, 32'(exp_update), 32'(update_angle));
    endtask

    // New status and angle inputs, then held
    task automatic randomize_inputs();
        @(posedge clock);
        drive_fault      <= 4'($urandom);
        drive_adc_temp   <= drive_temp_vec_t'($urandom);
        rot_fault        <= 4'($urandom);
        rot_startup_fail <= 4'($urandom);
        rot_adc_temp     <= rot_temp_vec_t'($urandom);
        current_angle    <= angle_vec_t'({$urandom, $urandom});
        angle_done       <= 4'($urandom);
    endtask

    task automatic test_reset();
        test_name = "reset";
        @(negedge clock);
        check_outputs('0, '0);
        read_range(0, 63);                 // Whole space reads zero
    endtask

    task automatic test_controls();
        reg_addr_t a;
        test_name = "control";
        repeat (3) begin
            for (int ch = 0; ch < NUM_DRIVE + NUM_ROTATION; ch++) begin
                if (ch < NUM_DRIVE)
                    a = drive_reg(ch, DRIVE_CTRL);
                else
                    a = rotation_reg(ch - NUM_DRIVE, ROT_CTRL);
                bus_write(a, reg_data_t'($urandom));
                @(negedge clock);
                check_outputs('0, '0);
                bus_read(a);
            end
        end
    endtask

    // Broadcasts, reserved 0x00 and two unmapped addresses
    task automatic test_broadcasts();
        reg_addr_t targets [6];
        test_name  = "broadcast";
        targets[0] = ADDR_BCAST_ALL;
        targets[1] = ADDR_BCAST_ROTATION;
        targets[2] = ADDR_BCAST_DRIVE;
        targets[3] = 6'h00;
        targets[4] = reg_addr_t'(ROT_END + int'($urandom_range(0, 63 - ROT_END)));
        targets[5] = 6'h3F;
        for (int i = 0; i < 6; i++) begin
            bus_write(targets[i], reg_data_t'($urandom));
            @(negedge clock);
            check_outputs('0, '0);
            read_controls();
            bus_read(targets[i]);          // Write-only or unmapped
        end
    endtask

    task automatic test_status();
        test_name = "status";
        repeat (4) begin
            randomize_inputs();
            read_range(int'(DRIVE_BASE), ROT_END - 1);
        end
    endtask

    task automatic test_targets();
        test_name = "target";
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            bus_write(rotation_reg(ch, ROT_CTRL), reg_data_t'($urandom));
            bus_write(rotation_reg(ch, ROT_TARGET), reg_data_t'($urandom));
            @(negedge clock);
            check_outputs('0, '0);         // Nibble and low byte joined
            bus_read(rotation_reg(ch, ROT_TARGET));
            bus_read(rotation_reg(ch, ROT_CTRL));
        end
    endtask

    task automatic test_strobes();
        reg_data_t               data;
        logic [NUM_ROTATION-1:0] exp_abort;
        logic [NUM_ROTATION-1:0] exp_update;
        test_name = "strobe";
        for (int ch = 0; ch < NUM_ROTATION; ch++) begin
            for (int pat = 0; pat < 4; pat++) begin
                data             = reg_data_t'($urandom);
                data[ABORT_BIT]  = pat[0];
                data[UPDATE_BIT] = pat[1];
                exp_abort        = '0;
                exp_update       = '0;
                exp_abort[ch]    = pat[0];
                exp_update[ch]   = pat[1];
                bus_write(rotation_reg(ch, ROT_CURR_HI), data);
                @(negedge clock);
                check_outputs(exp_abort, exp_update);  // Only this channel fires
                @(negedge clock);
                check_outputs('0, '0);                 // Gone after one cycle
                bus_read(rotation_reg(ch, ROT_CURR_HI));
            end
        end
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        model_reset();
        reset            <= 1'b1;
        address          <= '0;
        write_en         <= 1'b0;
        wr_data          <= '0;
        read_en          <= 1'b0;
        drive_fault      <= '0;
        drive_adc_temp   <= '0;
        rot_fault        <= '0;
        rot_startup_fail <= '0;
        rot_adc_temp     <= '0;
        current_angle    <= '0;
        angle_done       <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        test_reset();
        test_controls();
        test_broadcasts();
        test_status();
        test_targets();
        test_strobes();

        repeat (3) @(negedge clock);      // Let the last read land
        if (reads_checked == reads_issued) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Only %0d of %0d reads were compared", reads_checked, reads_issued);
            $display("FAIL: see errors above");
            $fatal(1, "reads left unchecked");
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+tb
verilog/motor_regs_pkg.sv
verilog/reg_bus_if.sv
verilog/drive_bank.sv
verilog/rotation_bank.sv
verilog/readback_mux.sv
verilog/motor_reg_file.sv
tb/tb_motor_reg_file.sv

//--- Makefile
# Verilator build and run of the motor register file testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_motor_reg_file
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

# Sources from the file list, plus the included model header
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) tb/tb_reg_model.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the log, not the simulator exit code
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
